// File: common/comm_pkg.sv
`default_nettype none

package comm_pkg;

  // 16-bit command, hi goes out on the wire first
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } cmd_t;

  ////////////////////
  // fsm states
  ////////////////////

  // serial transmitter
  typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_e;

  // serial receiver
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA} rx_state_e;

  // host side command sender
  typedef enum logic [1:0] {SEND_IDLE, SEND_HIGH, SEND_LOW} send_state_e;

  // device side byte pair assembler
  typedef enum logic {ASM_WAIT_HI, ASM_WAIT_LO} asm_state_e;

endpackage

`default_nettype wire

// File: uart/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx #(
  parameter int baud_div = 434  // clk cycles per bit
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        trmt,     // start a frame, only taken when idle
  input  wire  [7:0] tx_data,
  output logic       tx,
  output logic       tx_done   // level, end of stop bit until next trmt
);

  localparam int cnt_w = $clog2(baud_div);

  comm_pkg::tx_state_e state;

  logic [9:0]       shft;      // {stop, data, start}, lsb on the line
  logic [cnt_w-1:0] baud_cnt;
  logic [3:0]       bit_cnt;   // bits already shifted out
  logic             load;
  logic             bit_end;

  assign load    = trmt && (state == comm_pkg::TX_IDLE);
  assign bit_end = (baud_cnt == cnt_w'(baud_div - 1));
  assign tx      = shft[0];

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state    <= comm_pkg::TX_IDLE;
      shft     <= '1;  // line idles high
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (load) begin
      state    <= comm_pkg::TX_SHIFT;
      shft     <= {1'b1, tx_data, 1'b0};
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (state == comm_pkg::TX_SHIFT) begin
      if (bit_end) begin
        baud_cnt <= '0;
        shft     <= {1'b1, shft[9:1]};  // fill with idle level
        bit_cnt  <= bit_cnt + 4'd1;
        if (bit_cnt == 4'd9)
          state <= comm_pkg::TX_IDLE;  // stop bit done
      end else begin
        baud_cnt <= baud_cnt + cnt_w'(1);
      end
    end
  end

  // sr flop, frame end sets, accepted trmt clears
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      tx_done <= 1'b0;
    else if (load)
      tx_done <= 1'b0;
    else if (state == comm_pkg::TX_SHIFT && bit_end && bit_cnt == 4'd9)
      tx_done <= 1'b1;
  end

endmodule

`default_nettype wire

// File: uart/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx #(
  parameter int baud_div = 434  // clk cycles per bit
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rx,
  output logic [7:0] rx_data,
  output logic       rx_done   // one cycle at stop bit sample time
);

  localparam int cnt_w = $clog2(baud_div);

  comm_pkg::rx_state_e state;

  logic             rx_ff1, rx_ff2, rx_prev;  // sync chain + edge detect
  logic [cnt_w-1:0] baud_cnt;
  logic [3:0]       bit_cnt;
  logic             fall;
  logic             half_bit;
  logic             full_bit;

  assign fall     = rx_prev && !rx_ff2;
  assign half_bit = (baud_cnt == cnt_w'(baud_div / 2 - 1));
  assign full_bit = (baud_cnt == cnt_w'(baud_div - 1));

  // metastability flops, preset to idle level
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rx_ff1  <= 1'b1;
      rx_ff2  <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_ff1  <= rx;
      rx_ff2  <= rx_ff1;
      rx_prev <= rx_ff2;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state    <= comm_pkg::RX_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_done  <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      case (state)
        comm_pkg::RX_START: begin
          if (half_bit) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            // start bit still low at mid-bit, else a glitch
            state    <= rx_ff2 ? comm_pkg::RX_IDLE : comm_pkg::RX_DATA;
          end else begin
            baud_cnt <= baud_cnt + cnt_w'(1);
          end
        end
        comm_pkg::RX_DATA: begin
          if (full_bit) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd8) begin  // stop bit middle
              rx_done <= 1'b1;
              state   <= comm_pkg::RX_IDLE;
            end
          end else begin
            baud_cnt <= baud_cnt + cnt_w'(1);
          end
        end
        default: begin  // idle, hunt for start edge
          baud_cnt <= '0;
          if (fall)
            state <= comm_pkg::RX_START;
        end
      endcase
    end
  end

  // data shifter, lsb arrives first
  always_ff @(posedge clk) begin
    if (state == comm_pkg::RX_DATA && full_bit && bit_cnt != 4'd8)
      rx_data <= {rx_ff2, rx_data[7:1]};
  end

endmodule

`default_nettype wire

// File: uart/uart.sv
`timescale 1ns/1ns
`default_nettype none

module uart #(
  parameter int baud_div = 434
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rx,
  output logic       tx,
  input  wire  [7:0] tx_data,
  input  wire        trmt,
  output logic       tx_done,
  output logic [7:0] rx_data,     // last byte received
  output logic       rx_rdy,      // sticky until clr_rx_rdy
  input  wire        clr_rx_rdy
);

  logic [7:0] rx_shft;
  logic       rx_done;

  uart_tx #(.baud_div(baud_div)) u_uart_tx (
    .clk    (clk),
    .rst_n  (rst_n),
    .trmt   (trmt),
    .tx_data(tx_data),
    .tx     (tx),
    .tx_done(tx_done)
  );

  uart_rx #(.baud_div(baud_div)) u_uart_rx (
    .clk    (clk),
    .rst_n  (rst_n),
    .rx     (rx),
    .rx_data(rx_shft),
    .rx_done(rx_done)
  );

  // capture byte so next frame's shifting doesn't disturb it
  always_ff @(posedge clk) begin
    if (rx_done)
      rx_data <= rx_shft;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      rx_rdy <= 1'b0;
    else if (rx_done)  // set beats clear
      rx_rdy <= 1'b1;
    else if (clr_rx_rdy)
      rx_rdy <= 1'b0;
  end

endmodule

`default_nettype wire

// File: rtl/remote_comm.sv
`timescale 1ns/1ns
`default_nettype none

module remote_comm #(
  parameter int baud_div = 434
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             rx,
  output logic            tx,
  input  comm_pkg::cmd_t  cmd,
  input  wire             send_cmd,  // pulse, honoured in idle only
  output logic            cmd_sent,  // level, both bytes gone
  output logic            resp_rdy,
  output logic [7:0]      resp
);

  comm_pkg::send_state_e state, nxt_state;

  logic       trmt;
  logic       sel_hi;      // high byte straight from cmd
  logic       start;       // accepted send_cmd
  logic       set_sent;
  logic       tx_done;
  logic [7:0] tx_data;
  logic [7:0] low_byte;

  uart #(.baud_div(baud_div)) u_uart (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .tx        (tx),
    .tx_data   (tx_data),
    .trmt      (trmt),
    .tx_done   (tx_done),
    .rx_data   (resp),
    .rx_rdy    (resp_rdy),
    .clr_rx_rdy(start)     // old response dropped on new command
  );

  assign tx_data = sel_hi ? cmd.hi : low_byte;

  // low byte held for the second frame
  always_ff @(posedge clk) begin
    if (start)
      low_byte <= cmd.lo;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      cmd_sent <= 1'b0;
    else if (start)
      cmd_sent <= 1'b0;
    else if (set_sent)
      cmd_sent <= 1'b1;
  end

  ////////////////////
  // send fsm
  ////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= comm_pkg::SEND_IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    sel_hi    = 1'b0;
    trmt      = 1'b0;
    start     = 1'b0;
    set_sent  = 1'b0;
    case (state)
      comm_pkg::SEND_HIGH: begin
        if (tx_done) begin  // hi byte out, send lo
          trmt      = 1'b1;
          nxt_state = comm_pkg::SEND_LOW;
        end
      end
      comm_pkg::SEND_LOW: begin
        if (tx_done) begin
          set_sent  = 1'b1;
          nxt_state = comm_pkg::SEND_IDLE;
        end
      end
      default: begin
        if (send_cmd) begin
          sel_hi    = 1'b1;
          trmt      = 1'b1;
          start     = 1'b1;
          nxt_state = comm_pkg::SEND_HIGH;
        end
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/cmd_endpoint.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_endpoint #(
  parameter int baud_div = 434
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             rx,
  output logic            tx,
  output comm_pkg::cmd_t  rcvd_cmd,
  output logic            cmd_rdy,      // sticky
  input  wire             clr_cmd_rdy,
  input  wire             send_resp,    // pulse, dropped if tx busy
  input  wire  [7:0]      resp_in,
  output logic            resp_sent
);

  comm_pkg::asm_state_e state, nxt_state;

  logic       rx_rdy;
  logic       clr_rx_rdy;
  logic       take_hi;
  logic       take_lo;      // command complete
  logic [7:0] rx_data;
  logic [7:0] hi_byte;

  // response straight to transmitter, tx_done doubles as resp_sent
  uart #(.baud_div(baud_div)) u_uart (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .tx        (tx),
    .tx_data   (resp_in),
    .trmt      (send_resp),
    .tx_done   (resp_sent),
    .rx_data   (rx_data),
    .rx_rdy    (rx_rdy),
    .clr_rx_rdy(clr_rx_rdy)
  );

  ////////////////////
  // byte pair assembly
  ////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= comm_pkg::ASM_WAIT_HI;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state  = state;
    take_hi    = 1'b0;
    take_lo    = 1'b0;
    clr_rx_rdy = rx_rdy;  // every byte acked as soon as seen
    if (rx_rdy) begin
      if (state == comm_pkg::ASM_WAIT_LO) begin
        take_lo   = 1'b1;
        nxt_state = comm_pkg::ASM_WAIT_HI;
      end else begin
        take_hi   = 1'b1;
        nxt_state = comm_pkg::ASM_WAIT_LO;
      end
    end
  end

  // first byte parked so a held command stays intact
  always_ff @(posedge clk) begin
    if (take_hi)
      hi_byte <= rx_data;
    if (take_lo)
      rcvd_cmd <= '{hi: hi_byte, lo: rx_data};
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      cmd_rdy <= 1'b0;
    else if (take_lo)
      cmd_rdy <= 1'b1;
    else if (clr_cmd_rdy)
      cmd_rdy <= 1'b0;
  end

endmodule

`default_nettype wire

// File: rtl/comm_link_top.sv
`timescale 1ns/1ns
`default_nettype none

module comm_link_top #(
  parameter int baud_div = 434  // clk cycles per serial bit
) (
  input  wire             clk,
  input  wire             rst_n,
  // host side
  input  wire             send_cmd,
  input  comm_pkg::cmd_t  cmd,
  output logic            cmd_sent,
  output logic            resp_rdy,
  output logic [7:0]      resp,
  // device side
  output logic            cmd_rdy,
  output comm_pkg::cmd_t  rcvd_cmd,
  input  wire             clr_cmd_rdy,
  input  wire             send_resp,
  input  wire  [7:0]      resp_in,
  output logic            resp_sent
);

  logic host_tx;  // host -> endpoint
  logic dev_tx;   // endpoint -> host

  remote_comm #(.baud_div(baud_div)) u_remote_comm (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (dev_tx),
    .tx      (host_tx),
    .cmd     (cmd),
    .send_cmd(send_cmd),
    .cmd_sent(cmd_sent),
    .resp_rdy(resp_rdy),
    .resp    (resp)
  );

  cmd_endpoint #(.baud_div(baud_div)) u_cmd_endpoint (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (host_tx),
    .tx         (dev_tx),
    .rcvd_cmd   (rcvd_cmd),
    .cmd_rdy    (cmd_rdy),
    .clr_cmd_rdy(clr_cmd_rdy),
    .send_resp  (send_resp),
    .resp_in    (resp_in),
    .resp_sent  (resp_sent)
  );

endmodule

`default_nettype wire

// File: testbench/tb_comm_link.sv
`timescale 1ns/1ns
`default_nettype none

module tb_comm_link;

  localparam int baud           = 16;  // clk cycles per serial bit
  localparam int n_trans        = 12;
  localparam int sent_limit     = 20 * baud + 20;  // two frames plus slack
  localparam int resp_limit     = 10 * baud + 20;  // one frame plus slack
  localparam int sent_lat       = 2 * (10 * baud + 1) + 1;  // two frames and their turnaround edges
  localparam int timeout_cycles = n_trans * (30 * baud + 200);

  logic           clk = 1'b0;
  logic           rst_n;
  logic           send_cmd;
  comm_pkg::cmd_t cmd;
  logic           cmd_sent;
  logic           resp_rdy;
  logic [7:0]     resp;
  logic           cmd_rdy;
  comm_pkg::cmd_t rcvd_cmd;
  logic           clr_cmd_rdy;
  logic           send_resp;
  logic [7:0]     resp_in;
  logic           resp_sent;

  comm_pkg::cmd_t exp_cmd = '0;  // last command taken by the host
  logic [15:0]    lfsr    = 16'd96;
  int             cycles  = 0;

  always #5 clk = ~clk;

  comm_link_top #(.baud_div(baud)) u_comm_link_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .send_cmd   (send_cmd),
    .cmd        (cmd),
    .cmd_sent   (cmd_sent),
    .resp_rdy   (resp_rdy),
    .resp       (resp),
    .cmd_rdy    (cmd_rdy),
    .rcvd_cmd   (rcvd_cmd),
    .clr_cmd_rdy(clr_cmd_rdy),
    .send_resp  (send_resp),
    .resp_in    (resp_in),
    .resp_sent  (resp_sent)
  );

  ////////////////////
  // helpers
  ////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_val(input string test, input logic [15:0] expected,
                           input logic [15:0] actual);
    assert (actual === expected)
    else abort_run($sformatf("Mismatch in %s: expected %h, actual %h", test, expected, actual));
  endtask

  task automatic check_low(input string test, input logic actual);
    check_val(test, 16'd0, {15'd0, actual});
  endtask

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[14:0], lfsr[0]};  // one step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  ////////////////////
  // protocol checks
  ////////////////////

  cmd_path_chk: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_rdy) |-> (rcvd_cmd.hi == exp_cmd.hi && rcvd_cmd.lo == exp_cmd.lo))
    else abort_run($sformatf("Mismatch in cmd_path: expected %h, actual %h", exp_cmd, rcvd_cmd));

  // host flags drop on the edge after a request
  send_clear_chk: assert property (@(posedge clk) disable iff (!rst_n)
    send_cmd |=> (!cmd_sent && !resp_rdy))
    else abort_run("cmd_sent or resp_rdy still high the cycle after send_cmd");

  sent_hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_sent && !send_cmd) |=> cmd_sent)
    else abort_run("cmd_sent fell with no new send_cmd");

  cmd_clear_chk: assert property (@(posedge clk) disable iff (!rst_n)
    clr_cmd_rdy |=> !cmd_rdy)
    else abort_run("cmd_rdy still high the cycle after clr_cmd_rdy");

  resp_sent_chk: assert property (@(posedge clk) disable iff (!rst_n)
    send_resp |=> !resp_sent)
    else abort_run("resp_sent did not fall when the response frame started");

  // resp only moves with a new byte
  resp_hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(resp) |-> resp_rdy)
    else abort_run("resp changed with no response byte received");

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles)
      abort_run($sformatf("timeout, run went past %0d cycles", timeout_cycles));
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    logic [15:0] bits;
    logic [15:0] cmd_bits;
    logic [7:0]  r;
    logic [7:0]  last_resp;
    logic        extra;
    int          n;
    rst_n       = 1'b0;
    send_cmd    = 1'b0;
    cmd         = '0;
    clr_cmd_rdy = 1'b0;
    send_resp   = 1'b0;
    resp_in     = '0;
    last_resp   = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_low("reset_cmd_sent", cmd_sent);
    check_low("reset_resp_rdy", resp_rdy);
    check_low("reset_cmd_rdy", cmd_rdy);
    check_low("reset_resp_sent", resp_sent);

    for (int t = 0; t < n_trans; t++) begin
      draw_bits(16, cmd_bits);
      draw_bits(8, bits);
      r     = bits[7:0];
      extra = (t % 2 == 1);  // odd ones get a stray send_cmd
      send_cmd <= 1'b1;
      cmd      <= cmd_bits;
      exp_cmd  <= cmd_bits;
      @(posedge clk);
      send_cmd <= 1'b0;
      n = 0;
      do begin
        @(posedge clk);
        n++;
        if (n == 1 && t > 0)
          check_val("resp_hold", {8'd0, last_resp}, {8'd0, resp});
        if (extra && n == 100) begin  // stray request mid high byte
          send_cmd <= 1'b1;
          cmd      <= ~cmd_bits;
        end else begin
          send_cmd <= 1'b0;
        end
        if (n > sent_limit)
          abort_run("cmd_sent did not rise after send_cmd");
      end while (cmd_sent !== 1'b1);
      assert (n >= 20 * baud)
      else abort_run("cmd_sent rose before two frames could be sent");
      if (extra)
        check_val("sent_time", 16'(sent_lat), 16'(n));

      n = 0;
      while (cmd_rdy !== 1'b1) begin  // stop bit sampled mid-bit so normally already up
        @(posedge clk);
        n++;
        if (n > 20)
          abort_run("cmd_rdy did not rise with the command");
      end
      check_val("cmd_path", cmd_bits, rcvd_cmd);

      clr_cmd_rdy <= 1'b1;
      @(posedge clk);
      clr_cmd_rdy <= 1'b0;
      @(posedge clk);
      check_low("cmd_rdy_clear", cmd_rdy);

      send_resp <= 1'b1;
      resp_in   <= r;
      @(posedge clk);
      send_resp <= 1'b0;
      n = 0;
      while (resp_rdy !== 1'b1 || resp_sent !== 1'b1) begin
        @(posedge clk);
        n++;
        if (n > resp_limit)
          abort_run("response frame did not complete in time");
      end
      check_val("resp_path", {8'd0, r}, {8'd0, resp});
      last_resp = r;
    end

    repeat (4) @(posedge clk);
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
common/comm_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart.sv
rtl/remote_comm.sv
rtl/cmd_endpoint.sv
rtl/comm_link_top.sv
testbench/tb_comm_link.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_comm_link -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_comm_link)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Finished with no errors"; then
  exit 0
fi
exit 1
